//--- usb_reg_settings.svh
`ifndef USB_REG_SETTINGS_SVH
`define USB_REG_SETTINGS_SVH

// Byte counter width on the register bus
`define USB_REG_BYTECNT_SIZE 7

// Sample FIFO depth in words
`define USB_REG_FIFO_DEPTH 16

// Register map, one byte of address each
`define USB_REG_ADDR_CTRL   8'h01
`define USB_REG_ADDR_DECIM  8'h02
`define USB_REG_ADDR_STATUS 8'h03
`define USB_REG_ADDR_FIFO   8'h04

`endif

//--- usb_reg_pkg.sv
//////////////////////////////
// Shared types for the USB register front end and capture path
//////////////////////////////

package usb_reg_pkg;

   // One captured sample from the external stream
   typedef logic [31:0] sample_t;

   // Control register layout
   // Bit 0 is enable, bit 1 is clear, the rest is free for software
   typedef struct packed {
      logic [5:0] spare;
      // Self-clearing, reads back as 0
      logic       clear;
      // Capture on/off
      logic       enable;
   } ctrl_t;

   // Status as seen by the host
   // Byte 0 carries level, byte 1 bit 0 carries overflow
   typedef struct packed {
      // Sticky until a clear
      logic       overflow;
      // Words currently held in the FIFO
      logic [7:0] level;
   } status_t;

endpackage

//--- reg_bus_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_reg_settings.svh"

// Synchronous register bus between the front end and the register block
interface reg_bus_if;
   // Latched bus address
   logic [7:0]                       address;
   // Byte index within a multi-byte register
   logic [`USB_REG_BYTECNT_SIZE-1:0] bytecnt;
   // Write data from the host
   logic [7:0]                       datao;
   // Read data back to the host
   logic [7:0]                       datai;
   // High for the whole read, data due one cycle after it rises
   logic                             read;
   // One cycle at the tail of a read
   logic                             read_done;
   // One cycle per host write
   logic                             write;

   modport front (output address, bytecnt, datao, read, read_done, write, input datai);
   modport regs (input address, bytecnt, datao, read, read_done, write, output datai);

endinterface

`default_nettype wire

//--- usb_reg_main.sv
`timescale 1ns/1ns
`default_nettype none

module usb_reg_main (
   input  logic       cwusb_clk,
   input  logic       rst_n,

   // Parallel bus of the USB controller
   input  logic [7:0] cwusb_din,
   output logic [7:0] cwusb_dout,
   output logic       cwusb_isout,
   input  logic [7:0] cwusb_addr,
   input  logic       cwusb_rdn,
   input  logic       cwusb_wrn,
   input  logic       cwusb_cen,

   // Internal register bus
   reg_bus_if.front   bus
);

   // Host read request, both strobes low
   logic rd_req;
   logic isout_q;
   logic isout_dly;
   logic wrn_rs;
   logic wrn_rs_dly;
   logic write_dly;

   assign rd_req = ~cwusb_rdn & ~cwusb_cen;

   //////////////////////////////
   // Strobe resync
   //////////////////////////////

   // wrn idles high, so the chain resets high to avoid a false write edge
   always_ff @(posedge cwusb_clk) begin
      if (!rst_n) begin
         isout_q    <= 1'b0;
         isout_dly  <= 1'b0;
         wrn_rs     <= 1'b1;
         wrn_rs_dly <= 1'b1;
         bus.write  <= 1'b0;
         write_dly  <= 1'b0;
      end else begin
         isout_q    <= rd_req;
         isout_dly  <= isout_q;
         wrn_rs     <= cwusb_wrn;
         wrn_rs_dly <= wrn_rs;
         // Rising edge of the resynced wrn
         bus.write  <= wrn_rs & ~wrn_rs_dly;
         write_dly  <= bus.write;
      end
   end

   // Drivers stay on one extra cycle after rdn goes high
   assign cwusb_isout   = isout_q | isout_dly;
   assign bus.read      = cwusb_isout;
   // Last cycle of the stretched direction flag
   assign bus.read_done = isout_dly & ~isout_q;
   assign cwusb_dout    = bus.datai;

   //////////////////////////////
   // Address and write data
   //////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (!rst_n) begin
         bus.address <= 8'h00;
      end else begin
         bus.address <= cwusb_addr;
      end
   end

   // Data held while the write strobe is active
   always_ff @(posedge cwusb_clk) begin
      if (~cwusb_cen & ~wrn_rs) begin
         bus.datao <= cwusb_din;
      end
   end

   //////////////////////////////
   // Byte counter
   //////////////////////////////

   // New address restarts at byte 0, free-running wrap otherwise
   always_ff @(posedge cwusb_clk) begin
      if (!rst_n) begin
         bus.bytecnt <= '0;
      end else if (bus.address != cwusb_addr) begin
         bus.bytecnt <= '0;
      end else if (bus.read_done || write_dly) begin
         bus.bytecnt <= bus.bytecnt + 1'b1;
      end
   end

   // One write pulse per wrn rising edge
   a_write_single : assert property (@(posedge cwusb_clk) disable iff (!rst_n)
      bus.write |=> !bus.write);

   // Read completion only follows an active read
   a_done_after_read : assert property (@(posedge cwusb_clk) disable iff (!rst_n)
      bus.read_done |-> $past(cwusb_isout));

endmodule

`default_nettype wire

//--- capture_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_reg_settings.svh"

module capture_regs (
   input  logic                 cwusb_clk,
   input  logic                 rst_n,
   input  usb_reg_pkg::sample_t head,
   input  usb_reg_pkg::status_t status,
   reg_bus_if.regs              bus,
   output usb_reg_pkg::ctrl_t   ctrl,
   output logic [15:0]          decim,
   output logic                 pop
);

   logic wr_ctrl;
   logic wr_decim;
   logic fifo_sel;
   logic fifo_empty;
   // Byte lane of the head word
   logic [7:0] head_byte;

   assign wr_ctrl    = bus.write && (bus.address == `USB_REG_ADDR_CTRL);
   assign wr_decim   = bus.write && (bus.address == `USB_REG_ADDR_DECIM);
   assign fifo_sel   = (bus.address == `USB_REG_ADDR_FIFO);
   assign fifo_empty = (status.level == 8'd0);

   //////////////////////////////
   // Write side
   //////////////////////////////

   // Control byte, clear lives for one cycle only
   always_ff @(posedge cwusb_clk) begin
      if (!rst_n) begin
         ctrl <= '0;
      end else begin
         ctrl.clear <= 1'b0;
         if (wr_ctrl) begin
            ctrl <= usb_reg_pkg::ctrl_t'(bus.datao);
         end
      end
   end

   // Decimation, little-endian, low byte first
   always_ff @(posedge cwusb_clk) begin
      if (!rst_n) begin
         decim <= 16'h0000;
      end else if (wr_decim) begin
         if (bus.bytecnt[0]) begin
            decim[15:8] <= bus.datao;
         end else begin
            decim[7:0] <= bus.datao;
         end
      end
   end

   //////////////////////////////
   // Read side
   //////////////////////////////

   // LSB first, bytecnt mod 4 walks the word
   assign head_byte = head[{bus.bytecnt[1:0], 3'b000} +: 8];

   always_comb begin
      bus.datai = 8'h00;
      case (bus.address)
         `USB_REG_ADDR_CTRL: begin
            bus.datai = {ctrl.spare, 1'b0, ctrl.enable};
         end
         `USB_REG_ADDR_DECIM: begin
            bus.datai = bus.bytecnt[0] ? decim[15:8] : decim[7:0];
         end
         `USB_REG_ADDR_STATUS: begin
            bus.datai = bus.bytecnt[0] ? {7'b0, status.overflow} : status.level;
         end
         `USB_REG_ADDR_FIFO: begin
            // Empty FIFO reads as zero
            bus.datai = fifo_empty ? 8'h00 : head_byte;
         end
         default: begin
            bus.datai = 8'h00;
         end
      endcase
   end

   // Pop as the fourth byte read finishes
   assign pop = bus.read_done && fifo_sel && (bus.bytecnt[1:0] == 2'd3) && !fifo_empty;

   // Pop only on a non-empty FIFO, at the end of a host read
   a_pop_valid : assert property (@(posedge cwusb_clk) disable iff (!rst_n)
      pop |-> (status.level != 8'd0) && $past(bus.read));

endmodule

`default_nettype wire

//--- sample_decimator.sv
`timescale 1ns/1ns
`default_nettype none

module sample_decimator (
   input  logic                 cwusb_clk,
   input  logic                 rst_n,
   input  logic                 enable,
   input  logic [15:0]          decim,
   input  logic                 sample_valid,
   input  usb_reg_pkg::sample_t sample_data,
   output logic                 push,
   output usb_reg_pkg::sample_t push_data
);

   // Valid samples still to skip before the next kept one
   logic [15:0] skip_cnt;

   // Keep the sample when nothing is left to skip
   assign push      = enable && sample_valid && (skip_cnt == 16'd0);
   assign push_data = sample_data;

   //////////////////////////////
   // Skip counter
   //////////////////////////////

   // Disabled means idle at zero, first sample after enable is kept
   always_ff @(posedge cwusb_clk) begin
      if (!rst_n || !enable) begin
         skip_cnt <= 16'd0;
      end else if (sample_valid) begin
         if (skip_cnt == 16'd0) begin
            // Reload after each kept sample
            skip_cnt <= decim;
         end else begin
            skip_cnt <= skip_cnt - 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- sample_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_reg_settings.svh"

module sample_fifo (
   input  logic                 cwusb_clk,
   input  logic                 rst_n,
   input  logic                 clear,
   input  logic                 push,
   input  usb_reg_pkg::sample_t push_data,
   input  logic                 pop,
   output usb_reg_pkg::sample_t head,
   output usb_reg_pkg::status_t status
);

   localparam int DEPTH = `USB_REG_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   usb_reg_pkg::sample_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [7:0]       level;
   logic             overflow;
   logic             full;
   logic             empty;
   logic             do_push;
   logic             do_pop;

   assign full    = (level == 8'(DEPTH));
   assign empty   = (level == 8'd0);
   assign do_pop  = pop && !empty;
   // Full FIFO still takes a push when a pop frees a slot
   assign do_push = push && (!full || do_pop);

   //////////////////////////////
   // Pointers and level
   //////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (!rst_n || clear) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         level    <= 8'd0;
         overflow <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   level <= level + 8'd1;
            2'b01:   level <= level - 8'd1;
            default: level <= level;
         endcase
         // Dropped sample, sticky until clear
         if (push && !do_push) begin
            overflow <= 1'b1;
         end
      end
   end

   // Sample storage
   always_ff @(posedge cwusb_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   assign head            = mem[rd_ptr];
   assign status.level    = level;
   assign status.overflow = overflow;

   a_level_bound : assert property (@(posedge cwusb_clk) disable iff (!rst_n)
      level <= 8'(DEPTH));

endmodule

`default_nettype wire

//--- usb_capture_top.sv
`timescale 1ns/1ns
`default_nettype none

module usb_capture_top (
   input  logic        cwusb_clk,
   input  logic        rst_n,

   // USB controller parallel bus
   input  logic [7:0]  cwusb_din,
   output logic [7:0]  cwusb_dout,
   output logic        cwusb_isout,
   input  logic [7:0]  cwusb_addr,
   input  logic        cwusb_rdn,
   input  logic        cwusb_wrn,
   input  logic        cwusb_cen,

   // External sample stream
   input  logic        sample_valid,
   input  logic [31:0] sample_data
);

   // Register block to datapath
   usb_reg_pkg::ctrl_t   ctrl;
   logic [15:0]          decim;
   logic                 pop;
   // Decimator to FIFO
   logic                 push;
   usb_reg_pkg::sample_t push_data;
   // FIFO back to registers
   usb_reg_pkg::sample_t head;
   usb_reg_pkg::status_t status;

   reg_bus_if bus_i ();

   //////////////////////////////
   // Host side
   //////////////////////////////

   usb_reg_main u_reg_main (
      .cwusb_clk   (cwusb_clk),
      .rst_n       (rst_n),
      .cwusb_din   (cwusb_din),
      .cwusb_dout  (cwusb_dout),
      .cwusb_isout (cwusb_isout),
      .cwusb_addr  (cwusb_addr),
      .cwusb_rdn   (cwusb_rdn),
      .cwusb_wrn   (cwusb_wrn),
      .cwusb_cen   (cwusb_cen),
      .bus         (bus_i.front)
   );

   capture_regs u_regs (
      .cwusb_clk (cwusb_clk),
      .rst_n     (rst_n),
      .head      (head),
      .status    (status),
      .bus       (bus_i.regs),
      .ctrl      (ctrl),
      .decim     (decim),
      .pop       (pop)
   );

   //////////////////////////////
   // Capture path
   //////////////////////////////

   sample_decimator u_decimator (
      .cwusb_clk    (cwusb_clk),
      .rst_n        (rst_n),
      .enable       (ctrl.enable),
      .decim        (decim),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .push         (push),
      .push_data    (push_data)
   );

   sample_fifo u_fifo (
      .cwusb_clk (cwusb_clk),
      .rst_n     (rst_n),
      .clear     (ctrl.clear),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head      (head),
      .status    (status)
   );

endmodule

`default_nettype wire

//--- tb_usb_capture.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_reg_settings.svh"

module tb_usb_capture;

   localparam int DEPTH      = `USB_REG_FIFO_DEPTH;
   // About 300 accesses of 8 to 10 cycles plus capture windows, with margin
   localparam int MAX_CYCLES = 40000;

   logic        cwusb_clk;
   logic        rst_n;
   logic [7:0]  cwusb_din;
   logic [7:0]  cwusb_dout;
   logic        cwusb_isout;
   logic [7:0]  cwusb_addr;
   logic        cwusb_rdn;
   logic        cwusb_wrn;
   logic        cwusb_cen;
   logic        sample_valid;
   logic [31:0] sample_data;

   logic [31:0] lcg_state;
   // Valid samples sent since the last enable
   logic [31:0] valid_q[$];
   // Expected FIFO contents, oldest first
   logic [31:0] exp_q[$];
   int          model_decim;
   // Sticky like the hardware flag
   logic        model_ovf;

   // Handoff to the compare process
   event        cmp_ev;
   logic [7:0]  cmp_got;
   logic [7:0]  cmp_exp;
   string       cmp_name;

   int          check_count = 0;
   int          error_count = 0;
   int          cycle_count = 0;

   usb_capture_top DUT (
      .cwusb_clk    (cwusb_clk),
      .rst_n        (rst_n),
      .cwusb_din    (cwusb_din),
      .cwusb_dout   (cwusb_dout),
      .cwusb_isout  (cwusb_isout),
      .cwusb_addr   (cwusb_addr),
      .cwusb_rdn    (cwusb_rdn),
      .cwusb_wrn    (cwusb_wrn),
      .cwusb_cen    (cwusb_cen),
      .sample_valid (sample_valid),
      .sample_data  (sample_data)
   );

   // 100 ns period
   initial begin
      cwusb_clk = 1'b0;
      forever #50 cwusb_clk = ~cwusb_clk;
   end

   //////////////////////////////
   // Watchdog and compare
   //////////////////////////////

   always @(posedge cwusb_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: test sequence still running after %0d cycles", cycle_count);
         $display("Verification failed");
         $finish;
      end
   end

   always @(cmp_ev) begin
      check_count = check_count + 1;
      if (cmp_got !== cmp_exp) begin
         error_count = error_count + 1;
         $display("[ERROR] %0t ns %s: got 0x%02h, expected 0x%02h",
                  $time, cmp_name, cmp_got, cmp_exp);
      end
   end

   task automatic post_check(input logic [7:0] got, input logic [7:0] exp, input string name);
      cmp_got  = got;
      cmp_exp  = exp;
      cmp_name = name;
      -> cmp_ev;
   endtask

   //////////////////////////////
   // Host bus model
   //////////////////////////////

   // 4 strobe cycles, then room for the write pulse and byte counter
   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge cwusb_clk);
      cwusb_addr <= addr;
      cwusb_din  <= data;
      cwusb_cen  <= 1'b0;
      cwusb_wrn  <= 1'b0;
      repeat (4) @(posedge cwusb_clk);
      cwusb_wrn <= 1'b1;
      cwusb_cen <= 1'b1;
      repeat (5) @(posedge cwusb_clk);
   endtask

   // Data sampled mid-cycle in the last strobe cycle
   task automatic read_check(input logic [7:0] addr, input logic [7:0] exp, input string what);
      @(posedge cwusb_clk);
      cwusb_addr <= addr;
      cwusb_cen  <= 1'b0;
      cwusb_rdn  <= 1'b0;
      repeat (2) @(posedge cwusb_clk);
      @(negedge cwusb_clk);
      post_check({7'b0, cwusb_isout}, 8'h01, "cwusb_isout during read");
      @(posedge cwusb_clk);
      @(negedge cwusb_clk);
      post_check(cwusb_dout, exp, {"cwusb_dout at ", what});
      @(posedge cwusb_clk);
      cwusb_rdn <= 1'b1;
      cwusb_cen <= 1'b1;
      // read_done and pop land in here
      repeat (3) @(posedge cwusb_clk);
   endtask

   // Level then overflow, byte parity picks the field
   task automatic check_status(input int level, input logic ovf);
      read_check(`USB_REG_ADDR_STATUS, 8'(level), "STATUS level");
      read_check(`USB_REG_ADDR_STATUS, {7'b0, ovf}, "STATUS overflow");
   endtask

   // LSB first, four reads per word
   task automatic drain_words(input int n);
      logic [31:0] w;
      for (int k = 0; k < n; k++) begin
         w = exp_q[k];
         for (int b = 0; b < 4; b++) begin
            read_check(`USB_REG_ADDR_FIFO, w[8*b +: 8],
                       $sformatf("FIFO word %0d byte %0d", k, b));
         end
      end
   endtask

   //////////////////////////////
   // Sample source and model
   //////////////////////////////

   // Two LCG steps, upper halves only
   function automatic logic [31:0] lcg_next();
      logic [31:0] first;
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      first     = lcg_state;
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {first[31:16], lcg_state[31:16]};
   endfunction

   task automatic run_stream(input int n_valid);
      logic [31:0] r;
      logic [31:0] d;
      int          sent;
      sent = 0;
      while (sent < n_valid) begin
         @(posedge cwusb_clk);
         r = lcg_next();
         d = lcg_next();
         sample_valid <= r[0];
         sample_data  <= d;
         if (r[0]) begin
            valid_q.push_back(d);
            sent++;
         end
      end
      @(posedge cwusb_clk);
      sample_valid <= 1'b0;
   endtask

   // Keeps indices 0, N+1, 2(N+1) of the valid list, drops past the depth
   function automatic void build_model();
      exp_q.delete();
      for (int i = 0; i < valid_q.size(); i++) begin
         if (i % (model_decim + 1) == 0) begin
            if (exp_q.size() < DEPTH) begin
               exp_q.push_back(valid_q[i]);
            end else begin
               model_ovf = 1'b1;
            end
         end
      end
   endfunction

   // Disable restarts the decimator count, then enable
   task automatic start_capture(input logic [15:0] decim);
      write_reg(`USB_REG_ADDR_CTRL, 8'h00);
      write_reg(`USB_REG_ADDR_DECIM, decim[7:0]);
      write_reg(`USB_REG_ADDR_DECIM, decim[15:8]);
      write_reg(`USB_REG_ADDR_CTRL, 8'h01);
      model_decim = int'(decim);
      valid_q.delete();
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      lcg_state    = 32'h544e_7ed7;
      model_decim  = 0;
      model_ovf    = 1'b0;
      rst_n        <= 1'b0;
      cwusb_din    <= 8'h00;
      cwusb_addr   <= 8'h00;
      cwusb_rdn    <= 1'b1;
      cwusb_wrn    <= 1'b1;
      cwusb_cen    <= 1'b1;
      sample_valid <= 1'b0;
      sample_data  <= 32'h0;
      repeat (16) @(posedge cwusb_clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge cwusb_clk);

      // Reset state
      @(negedge cwusb_clk);
      post_check({7'b0, cwusb_isout}, 8'h00, "cwusb_isout after reset");
      read_check(`USB_REG_ADDR_CTRL, 8'h00, "CTRL after reset");
      read_check(`USB_REG_ADDR_DECIM, 8'h00, "DECIM after reset");
      check_status(0, 1'b0);

      // Register readback, clear bit reads 0
      write_reg(`USB_REG_ADDR_CTRL, 8'ha6);
      write_reg(`USB_REG_ADDR_DECIM, 8'hef);
      write_reg(`USB_REG_ADDR_DECIM, 8'hbe);
      read_check(`USB_REG_ADDR_DECIM, 8'hef, "DECIM byte 0");
      read_check(`USB_REG_ADDR_DECIM, 8'hbe, "DECIM byte 1");
      read_check(`USB_REG_ADDR_CTRL, 8'ha6 & ~8'h02, "CTRL readback");

      // Unmapped addresses and byte restart
      read_check(8'h00, 8'h00, "address 0x00");
      read_check(8'h7f, 8'h00, "address 0x7f");
      read_check(8'hff, 8'h00, "address 0xff");
      read_check(`USB_REG_ADDR_DECIM, 8'hef, "DECIM byte 0");
      // Odd number of reads elsewhere, a counter without restart lands on byte 1
      read_check(8'h55, 8'h00, "address 0x55");
      read_check(8'haa, 8'h00, "address 0xaa");
      read_check(`USB_REG_ADDR_DECIM, 8'hef, "DECIM byte 0 after address change");
      read_check(`USB_REG_ADDR_DECIM, 8'hbe, "DECIM byte 1");

      // Decimation by 3
      start_capture(16'd2);
      run_stream(30);
      build_model();
      check_status(exp_q.size(), model_ovf);
      drain_words(exp_q.size());

      // Drained FIFO
      check_status(0, model_ovf);
      read_check(`USB_REG_ADDR_FIFO, 8'h00, "empty FIFO");
      read_check(`USB_REG_ADDR_FIFO, 8'h00, "empty FIFO");

      // Overrun keeps the first 16 words
      start_capture(16'd0);
      run_stream(24);
      build_model();
      check_status(exp_q.size(), model_ovf);
      drain_words(exp_q.size());
      check_status(0, model_ovf);
      // Every slot now holds stale data
      read_check(`USB_REG_ADDR_FIFO, 8'h00, "empty FIFO after wrap");
      read_check(`USB_REG_ADDR_FIFO, 8'h00, "empty FIFO after wrap");

      // Refill, then clear
      start_capture(16'd0);
      run_stream(6);
      build_model();
      check_status(exp_q.size(), model_ovf);
      write_reg(`USB_REG_ADDR_CTRL, 8'h02);
      model_ovf = 1'b0;
      exp_q.delete();
      check_status(0, 1'b0);

      // Fresh capture after clear
      start_capture(16'd1);
      run_stream(20);
      build_model();
      check_status(exp_q.size(), model_ovf);
      drain_words(exp_q.size());

      $display("Run complete: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
usb_reg_pkg.sv
reg_bus_if.sv
usb_reg_main.sv
capture_regs.sv
sample_decimator.sv
sample_fifo.sv
usb_capture_top.sv
tb_usb_capture.sv

//--- Makefile
# Verilator simulation of the USB capture register front end

TOP = tb_usb_capture

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module usb_capture_top

clean:
	rm -rf obj_dir sim.log
